// ==== include/dcache_macros.svh ====
// Data cache geometry, address slicing widths and tag entry layout
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Byte address, data word and byte lanes
`define DC_ADDR_W      32
`define DC_WORD_W      32
`define DC_BSEL_W      4

// 32-byte lines of eight words
`define DC_BLOCK_W     5
`define DC_WORDS       8
`define DC_WORD_OFS_W  3

// 128 sets, two ways each
`define DC_SET_W       7
`define DC_SETS        128
`define DC_WAYS        2

// Tag is everything above set index and line offset
`define DC_TAG_W       (`DC_ADDR_W - `DC_SET_W - `DC_BLOCK_W)

// Way memory word address, set index then word in line
`define DC_WAY_ADDR_W  (`DC_SET_W + `DC_WORD_OFS_W)

// Tag entry is {lru, valid1, tag1, valid0, tag0}
`define DC_V0_BIT      `DC_TAG_W
`define DC_V1_BIT      (2 * `DC_TAG_W + 1)
`define DC_LRU_BIT     (2 * `DC_TAG_W + 2)
`define DC_TE_W        (2 * `DC_TAG_W + 3)

`endif

// ==== source/dcache_pkg.sv ====
// Shared vector types and refill state encoding for the two-way data cache
`default_nettype none
`include "dcache_macros.svh"

package dcache_pkg;

   // CPU side quantities
   typedef logic [`DC_ADDR_W-1:0]  addr_t;
   typedef logic [`DC_WORD_W-1:0]  word_t;
   typedef logic [`DC_BSEL_W-1:0]  bsel_t;

   // Address fields
   typedef logic [`DC_SET_W-1:0]      set_t;
   typedef logic [`DC_TAG_W-1:0]      tag_t;
   typedef logic [`DC_WORD_OFS_W-1:0] word_ofs_t;

   // Line address, byte address without the line offset
   typedef logic [`DC_ADDR_W-`DC_BLOCK_W-1:0] line_addr_t;

   // One tag memory word covering both ways of a set
   typedef logic [`DC_TE_W-1:0] tag_entry_t;

   // One-hot way choice, bit 0 is way 0
   typedef logic [`DC_WAYS-1:0] way_sel_t;

   // Refill engine states
   typedef enum logic [1:0] {
      ST_SWEEP,   // clearing all tag entries after reset
      ST_IDLE,    // pipeline owns the memories
      ST_FILL,    // line words arriving from memory
      ST_TAG      // install new tag, one cycle
   } refill_state_t;

endpackage

`default_nettype wire

// ==== source/dcache_dpram.sv ====
// Dual-port RAM with registered read and bypass of a same-edge write
`timescale 1ns/1ns
`default_nettype none

module dcache_dpram #(
   parameter int ADDR_W = 7,
   parameter int DATA_W = 32
) (
   input  wire               clk,
   input  wire  [ADDR_W-1:0] raddr_i,
   input  wire  [ADDR_W-1:0] waddr_i,
   input  wire               we_i,
   input  wire  [DATA_W-1:0] din_i,
   output logic [DATA_W-1:0] dout_o
);

   // Storage array
   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
   end

   // Same entry written this edge, return the new word
   // Keeps LRU and merged data visible to the very next lookup
   always_ff @(posedge clk) begin
      if (we_i && (waddr_i == raddr_i)) begin
         dout_o <= din_i;
      end else begin
         dout_o <= mem[raddr_i];
      end
   end

endmodule

`default_nettype wire

// ==== source/dcache_lookup_stage.sv ====
// Cache lookup stage accepting or holding a request and steering memory reads
`timescale 1ns/1ns
`default_nettype none
`include "dcache_macros.svh"

module dcache_lookup_stage (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        req_valid_i,
   input  wire                        req_we_i,
   input  wire dcache_pkg::addr_t     req_addr_i,
   input  wire dcache_pkg::word_t     req_wdata_i,
   input  wire dcache_pkg::bsel_t     req_bsel_i,
   input  wire                        stall_i,
   input  wire                        fill_busy_i,
   output logic                       req_ready_o,
   output dcache_pkg::set_t           tag_raddr_o,
   output logic [`DC_WAY_ADDR_W-1:0]  way_raddr_o,
   output logic                       s1_valid_o,
   output logic                       s1_we_o,
   output dcache_pkg::addr_t          s1_addr_o,
   output dcache_pkg::word_t          s1_wdata_o,
   output dcache_pkg::bsel_t          s1_bsel_o
);

   import dcache_pkg::*;

   logic  accept;
   addr_t rd_addr;

   // Closed during sweep, refill and while a read miss sits in the hit stage
   assign req_ready_o = !stall_i && !fill_busy_i;
   assign accept      = req_valid_i && req_ready_o;

   // Held request re-reads its set every cycle of the miss
   // Read on the tag write edge is the replay lookup of the new line
   assign rd_addr     = stall_i ? s1_addr_o : req_addr_i;
   assign tag_raddr_o = rd_addr[`DC_BLOCK_W +: `DC_SET_W];
   assign way_raddr_o = rd_addr[2 +: `DC_WAY_ADDR_W];

   // Valid bit frozen while stalled, bubble otherwise
   always_ff @(posedge clk) begin
      if (rst) begin
         s1_valid_o <= 1'b0;
      end else if (!stall_i) begin
         s1_valid_o <= accept;
      end
   end

   // Request payload
   always_ff @(posedge clk) begin
      if (accept) begin
         s1_we_o    <= req_we_i;
         s1_addr_o  <= req_addr_i;
         s1_wdata_o <= req_wdata_i;
         s1_bsel_o  <= req_bsel_i;
      end
   end

   // Missed read stays in place until the refilled line answers it
   a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
      stall_i |=> s1_valid_o && $stable(s1_addr_o));

endmodule

`default_nettype wire

// ==== source/dcache_hit_stage.sv ====
// Cache hit stage with tag compare, byte merge, LRU update and miss detection
`timescale 1ns/1ns
`default_nettype none
`include "dcache_macros.svh"

module dcache_hit_stage (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          s1_valid_i,
   input  wire                          s1_we_i,
   input  wire dcache_pkg::addr_t       s1_addr_i,
   input  wire dcache_pkg::word_t       s1_wdata_i,
   input  wire dcache_pkg::bsel_t       s1_bsel_i,
   input  wire dcache_pkg::tag_entry_t  tag_rdata_i,
   input  wire dcache_pkg::word_t       way0_rdata_i,
   input  wire dcache_pkg::word_t       way1_rdata_i,
   output logic                         rsp_valid_o,
   output dcache_pkg::word_t            rsp_rdata_o,
   output logic                         stall_o,
   output logic                         miss_o,
   output dcache_pkg::line_addr_t       miss_line_o,
   output dcache_pkg::way_sel_t         victim_o,
   output dcache_pkg::tag_entry_t       tag_old_o,
   output logic                         tag_we_o,
   output dcache_pkg::tag_entry_t       tag_wdata_o,
   output dcache_pkg::way_sel_t         way_we_o,
   output dcache_pkg::word_t            way_wdata_o
);

   import dcache_pkg::*;

   tag_t     s1_tag;
   way_sel_t hit_way;
   logic     hit;
   word_t    hit_word;
   logic     miss_sent_q;

   assign s1_tag = s1_addr_i[`DC_ADDR_W-1 -: `DC_TAG_W];

   // Valid and tag compare per way
   assign hit_way[0] = tag_rdata_i[`DC_V0_BIT] &&
                       (tag_rdata_i[`DC_TAG_W-1:0] == s1_tag);
   assign hit_way[1] = tag_rdata_i[`DC_V1_BIT] &&
                       (tag_rdata_i[`DC_V1_BIT-1 -: `DC_TAG_W] == s1_tag);
   assign hit        = |hit_way;

   assign hit_word = hit_way[1] ? way1_rdata_i : way0_rdata_i;

   // Reads answer on a hit, writes always answer the same cycle
   assign rsp_valid_o = s1_valid_i && (hit || s1_we_i);
   assign rsp_rdata_o = hit_word;

   // Enabled lanes from the CPU, the rest from the stored word
   always_comb begin
      for (int b = 0; b < `DC_BSEL_W; b++) begin
         way_wdata_o[8*b +: 8] = s1_bsel_i[b] ? s1_wdata_i[8*b +: 8] : hit_word[8*b +: 8];
      end
   end

   // Write miss goes around the cache, no allocation
   assign way_we_o = (s1_valid_i && s1_we_i) ? hit_way : '0;

   // Any hit rewrites the entry with LRU pointing away from the hit way
   assign tag_we_o = s1_valid_i && hit;
   always_comb begin
      tag_wdata_o              = tag_rdata_i;
      tag_wdata_o[`DC_LRU_BIT] = hit_way[0];
   end

   // Read miss holds the pipeline until the refill lands
   assign stall_o     = s1_valid_i && !s1_we_i && !hit;
   assign miss_line_o = s1_addr_i[`DC_ADDR_W-1:`DC_BLOCK_W];
   assign victim_o    = tag_rdata_i[`DC_LRU_BIT] ? way_sel_t'(2'b10) : way_sel_t'(2'b01);
   assign tag_old_o   = tag_rdata_i;

   // Refill request is a single pulse at the start of each stall
   assign miss_o = stall_o && !miss_sent_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         miss_sent_q <= 1'b0;
      end else begin
         miss_sent_q <= stall_o;
      end
   end

   // Refill never installs a tag already present in the other way
   a_one_way_hit: assert property (@(posedge clk) disable iff (rst)
      s1_valid_i |-> !(hit_way[0] && hit_way[1]));

endmodule

`default_nettype wire

// ==== source/dcache_refill_engine.sv ====
// Cache refill engine, tag sweep after reset and line fill into the victim way
`timescale 1ns/1ns
`default_nettype none
`include "dcache_macros.svh"

module dcache_refill_engine (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          miss_i,
   input  wire dcache_pkg::line_addr_t  miss_line_i,
   input  wire dcache_pkg::way_sel_t    victim_i,
   input  wire dcache_pkg::tag_entry_t  tag_old_i,
   input  wire                          refill_valid_i,
   input  wire dcache_pkg::word_t       refill_data_i,
   output logic                         fill_busy_o,
   output logic                         refill_req_o,
   output dcache_pkg::line_addr_t       refill_addr_o,
   output logic                         tag_we_o,
   output dcache_pkg::set_t             tag_waddr_o,
   output dcache_pkg::tag_entry_t       tag_wdata_o,
   output dcache_pkg::way_sel_t         way_we_o,
   output logic [`DC_WAY_ADDR_W-1:0]    way_waddr_o,
   output dcache_pkg::word_t            way_wdata_o
);

   import dcache_pkg::*;

   refill_state_t state_q;
   set_t          sweep_cnt_q;
   word_ofs_t     word_cnt_q;
   line_addr_t    line_q;
   way_sel_t      victim_q;
   tag_entry_t    old_q;
   set_t          line_set;
   tag_t          line_tag;

   assign line_set = line_q[`DC_SET_W-1:0];
   assign line_tag = line_q[`DC_ADDR_W-`DC_BLOCK_W-1 -: `DC_TAG_W];

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q     <= ST_SWEEP;
         sweep_cnt_q <= '0;
         word_cnt_q  <= '0;
      end else begin
         case (state_q)
            // One set cleared per cycle
            ST_SWEEP: begin
               sweep_cnt_q <= sweep_cnt_q + 1'b1;
               if (sweep_cnt_q == set_t'(`DC_SETS - 1)) begin
                  state_q <= ST_IDLE;
               end
            end
            ST_IDLE: begin
               word_cnt_q <= '0;
               if (miss_i) begin
                  state_q <= ST_FILL;
               end
            end
            // Gaps in refill_valid_i just stretch this state
            ST_FILL: begin
               if (refill_valid_i) begin
                  word_cnt_q <= word_cnt_q + 1'b1;
                  if (word_cnt_q == word_ofs_t'(`DC_WORDS - 1)) begin
                     state_q <= ST_TAG;
                  end
               end
            end
            ST_TAG: begin
               state_q <= ST_IDLE;
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // Miss context, taken once when the refill starts
   always_ff @(posedge clk) begin
      if ((state_q == ST_IDLE) && miss_i) begin
         line_q   <= miss_line_i;
         victim_q <= victim_i;
         old_q    <= tag_old_i;
      end
   end

   // Engine owns both write ports outside ST_IDLE
   assign fill_busy_o   = (state_q != ST_IDLE);
   assign refill_req_o  = (state_q == ST_FILL);
   assign refill_addr_o = line_q;

   // Words land in order, word 0 first
   assign way_we_o    = (refill_req_o && refill_valid_i) ? victim_q : '0;
   assign way_waddr_o = {line_set, word_cnt_q};
   assign way_wdata_o = refill_data_i;

   assign tag_we_o    = (state_q == ST_SWEEP) || (state_q == ST_TAG);
   assign tag_waddr_o = (state_q == ST_SWEEP) ? sweep_cnt_q : line_set;

   // New tag valid in the victim half, other half kept, LRU to the other way
   always_comb begin
      tag_wdata_o = '0;
      if (state_q == ST_TAG) begin
         tag_wdata_o = old_q;
         if (victim_q[1]) begin
            tag_wdata_o[`DC_V1_BIT -: `DC_TAG_W+1] = {1'b1, line_tag};
         end else begin
            tag_wdata_o[`DC_V0_BIT:0] = {1'b1, line_tag};
         end
         tag_wdata_o[`DC_LRU_BIT] = victim_q[0];
      end
   end

   // Memory only returns data for an open refill request
   a_valid_in_refill: assert property (@(posedge clk) disable iff (rst)
      refill_valid_i |-> refill_req_o);

endmodule

`default_nettype wire

// ==== source/dcache_top.sv ====
// Two-way data cache top joining both pipeline stages, refill engine and memories
`timescale 1ns/1ns
`default_nettype none
`include "dcache_macros.svh"

module dcache_top (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          req_valid_i,
   output logic                         req_ready_o,
   input  wire                          req_we_i,
   input  wire dcache_pkg::addr_t       req_addr_i,
   input  wire dcache_pkg::word_t       req_wdata_i,
   input  wire dcache_pkg::bsel_t       req_bsel_i,
   output logic                         rsp_valid_o,
   output dcache_pkg::word_t            rsp_rdata_o,
   output logic                         refill_req_o,
   output dcache_pkg::line_addr_t       refill_addr_o,
   input  wire                          refill_valid_i,
   input  wire dcache_pkg::word_t       refill_data_i
);

   import dcache_pkg::*;

   // Lookup stage to hit stage
   logic       s1_valid;
   logic       s1_we;
   addr_t      s1_addr;
   word_t      s1_wdata;
   bsel_t      s1_bsel;

   // Memory read side
   set_t                       tag_raddr;
   logic [`DC_WAY_ADDR_W-1:0]  way_raddr;
   tag_entry_t                 tag_rdata;
   word_t                      way0_rdata;
   word_t                      way1_rdata;

   // Hit stage to refill engine
   logic       stall;
   logic       miss;
   line_addr_t miss_line;
   way_sel_t   victim;
   tag_entry_t tag_old;
   logic       fill_busy;

   // Write port sources
   logic                       hs_tag_we;
   tag_entry_t                 hs_tag_wdata;
   way_sel_t                   hs_way_we;
   word_t                      hs_way_wdata;
   logic                       fe_tag_we;
   set_t                       fe_tag_waddr;
   tag_entry_t                 fe_tag_wdata;
   way_sel_t                   fe_way_we;
   logic [`DC_WAY_ADDR_W-1:0]  fe_way_waddr;
   word_t                      fe_way_wdata;

   // Selected write ports
   logic                       tag_we;
   set_t                       tag_waddr;
   tag_entry_t                 tag_wdata;
   way_sel_t                   way_we;
   logic [`DC_WAY_ADDR_W-1:0]  way_waddr;
   word_t                      way_wdata;

   dcache_lookup_stage u_lookup (
      .clk         (clk),
      .rst         (rst),
      .req_valid_i (req_valid_i),
      .req_we_i    (req_we_i),
      .req_addr_i  (req_addr_i),
      .req_wdata_i (req_wdata_i),
      .req_bsel_i  (req_bsel_i),
      .stall_i     (stall),
      .fill_busy_i (fill_busy),
      .req_ready_o (req_ready_o),
      .tag_raddr_o (tag_raddr),
      .way_raddr_o (way_raddr),
      .s1_valid_o  (s1_valid),
      .s1_we_o     (s1_we),
      .s1_addr_o   (s1_addr),
      .s1_wdata_o  (s1_wdata),
      .s1_bsel_o   (s1_bsel)
   );

   dcache_hit_stage u_hit (
      .clk          (clk),
      .rst          (rst),
      .s1_valid_i   (s1_valid),
      .s1_we_i      (s1_we),
      .s1_addr_i    (s1_addr),
      .s1_wdata_i   (s1_wdata),
      .s1_bsel_i    (s1_bsel),
      .tag_rdata_i  (tag_rdata),
      .way0_rdata_i (way0_rdata),
      .way1_rdata_i (way1_rdata),
      .rsp_valid_o  (rsp_valid_o),
      .rsp_rdata_o  (rsp_rdata_o),
      .stall_o      (stall),
      .miss_o       (miss),
      .miss_line_o  (miss_line),
      .victim_o     (victim),
      .tag_old_o    (tag_old),
      .tag_we_o     (hs_tag_we),
      .tag_wdata_o  (hs_tag_wdata),
      .way_we_o     (hs_way_we),
      .way_wdata_o  (hs_way_wdata)
   );

   dcache_refill_engine u_refill (
      .clk            (clk),
      .rst            (rst),
      .miss_i         (miss),
      .miss_line_i    (miss_line),
      .victim_i       (victim),
      .tag_old_i      (tag_old),
      .refill_valid_i (refill_valid_i),
      .refill_data_i  (refill_data_i),
      .fill_busy_o    (fill_busy),
      .refill_req_o   (refill_req_o),
      .refill_addr_o  (refill_addr_o),
      .tag_we_o       (fe_tag_we),
      .tag_waddr_o    (fe_tag_waddr),
      .tag_wdata_o    (fe_tag_wdata),
      .way_we_o       (fe_way_we),
      .way_waddr_o    (fe_way_waddr),
      .way_wdata_o    (fe_way_wdata)
   );

   // Engine owns the write ports during sweep and refill
   // Hit stage writes go to the set and word of the request in flight
   assign tag_we    = fill_busy ? fe_tag_we    : hs_tag_we;
   assign tag_waddr = fill_busy ? fe_tag_waddr : s1_addr[`DC_BLOCK_W +: `DC_SET_W];
   assign tag_wdata = fill_busy ? fe_tag_wdata : hs_tag_wdata;
   assign way_we    = fill_busy ? fe_way_we    : hs_way_we;
   assign way_waddr = fill_busy ? fe_way_waddr : s1_addr[2 +: `DC_WAY_ADDR_W];
   assign way_wdata = fill_busy ? fe_way_wdata : hs_way_wdata;

   // Tag memory, one entry per set
   dcache_dpram #(.ADDR_W(`DC_SET_W), .DATA_W(`DC_TE_W)) u_tag_ram (
      .clk     (clk),
      .raddr_i (tag_raddr),
      .waddr_i (tag_waddr),
      .we_i    (tag_we),
      .din_i   (tag_wdata),
      .dout_o  (tag_rdata)
   );

   // Data memories, one per way
   dcache_dpram #(.ADDR_W(`DC_WAY_ADDR_W), .DATA_W(`DC_WORD_W)) u_way0_ram (
      .clk     (clk),
      .raddr_i (way_raddr),
      .waddr_i (way_waddr),
      .we_i    (way_we[0]),
      .din_i   (way_wdata),
      .dout_o  (way0_rdata)
   );

   dcache_dpram #(.ADDR_W(`DC_WAY_ADDR_W), .DATA_W(`DC_WORD_W)) u_way1_ram (
      .clk     (clk),
      .raddr_i (way_raddr),
      .waddr_i (way_waddr),
      .we_i    (way_we[1]),
      .din_i   (way_wdata),
      .dout_o  (way1_rdata)
   );

   // Hit stage stays quiet while the engine holds the memories
   a_single_writer: assert property (@(posedge clk) disable iff (rst)
      fill_busy |-> !hs_tag_we && (hs_way_we == '0));

endmodule

`default_nettype wire

// ==== verification/dcache_tb.sv ====
// Data cache testbench with shadow memory, refill responder and stimulus table
`timescale 1ns/1ns
`default_nettype none
`include "dcache_macros.svh"

module dcache_tb;

   import dcache_pkg::*;

   localparam logic [31:0] SEED       = 32'h279cc1f9;
   localparam int          NUM_ROWS   = 15;
   localparam int          BURST_LEN  = 4;
   localparam addr_t       BURST_BASE = 32'h0000_5100;
   // Reset, tag sweep, then a generous budget per request
   localparam int          CYCLE_LIMIT = 5 + `DC_SETS + 40 * (NUM_ROWS + BURST_LEN);

   logic       clk;
   logic       rst;
   logic       req_valid_i;
   logic       req_ready_o;
   logic       req_we_i;
   addr_t      req_addr_i;
   word_t      req_wdata_i;
   bsel_t      req_bsel_i;
   logic       rsp_valid_o;
   word_t      rsp_rdata_o;
   logic       refill_req_o;
   line_addr_t refill_addr_o;
   logic       refill_valid_i;
   word_t      refill_data_i;

   // Stimulus table, one request per row
   logic       tbl_we     [NUM_ROWS];
   addr_t      tbl_addr   [NUM_ROWS];
   word_t      tbl_wdata  [NUM_ROWS];
   bsel_t      tbl_bsel   [NUM_ROWS];
   logic       tbl_refill [NUM_ROWS];

   // Shadow memory, only written words are stored
   addr_t      mem_addr_q [$];
   word_t      mem_data_q [$];

   logic [31:0] gap_rng;
   int          words_sent;
   int          cycle_cnt;
   int          err_cnt;
   int          test_cnt;
   int          test_fail_cnt;
   int          r;

   dcache_top u_dut (
      .clk            (clk),
      .rst            (rst),
      .req_valid_i    (req_valid_i),
      .req_ready_o    (req_ready_o),
      .req_we_i       (req_we_i),
      .req_addr_i     (req_addr_i),
      .req_wdata_i    (req_wdata_i),
      .req_bsel_i     (req_bsel_i),
      .rsp_valid_o    (rsp_valid_o),
      .rsp_rdata_o    (rsp_rdata_o),
      .refill_req_o   (refill_req_o),
      .refill_addr_o  (refill_addr_o),
      .refill_valid_i (refill_valid_i),
      .refill_data_i  (refill_data_i)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Untouched memory word, hashed from the full word address
   function automatic word_t addr_hash(input addr_t a);
      return xorshift32(xorshift32({a[31:2], 2'b00} ^ SEED));
   endfunction

   function automatic word_t mem_read(input addr_t a);
      word_t w;
      int    i;
      w = addr_hash(a);
      for (i = 0; i < mem_addr_q.size(); i++) begin
         if (mem_addr_q[i] == {a[31:2], 2'b00})
            w = mem_data_q[i];
      end
      return w;
   endfunction

   // Byte-enabled write into the shadow
   task automatic mem_write(input addr_t a, input word_t d, input bsel_t be);
      word_t w;
      int    b;
      int    i;
      int    found;
      w = mem_read(a);
      for (b = 0; b < `DC_BSEL_W; b++) begin
         if (be[b])
            w[8*b +: 8] = d[8*b +: 8];
      end
      found = 0;
      for (i = 0; i < mem_addr_q.size(); i++) begin
         if (mem_addr_q[i] == {a[31:2], 2'b00}) begin
            mem_data_q[i] = w;
            found = 1;
         end
      end
      if (found == 0) begin
         mem_addr_q.push_back({a[31:2], 2'b00});
         mem_data_q.push_back(w);
      end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_line(input string name, input line_addr_t got, input line_addr_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s: got 0x%07h expected 0x%07h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic set_row(input int idx, input logic we, input addr_t a, input word_t d,
                          input bsel_t be, input logic refill);
      tbl_we[idx]     = we;
      tbl_addr[idx]   = a;
      tbl_wdata[idx]  = d;
      tbl_bsel[idx]   = be;
      tbl_refill[idx] = refill;
   endtask

   task automatic load_table();
      // Line D in set 8, line E in set 16
      set_row(0,  1'b0, 32'h0000_5104, '0,            4'b0000, 1'b1);
      set_row(1,  1'b0, 32'h0000_511c, '0,            4'b0000, 1'b0);
      set_row(2,  1'b1, 32'h0000_5108, 32'ha5a5_5a5a, 4'b0110, 1'b0);
      set_row(3,  1'b0, 32'h0000_5108, '0,            4'b0000, 1'b0);
      // Write miss, then read back through a refill
      set_row(4,  1'b1, 32'h0000_720c, 32'h1234_5678, 4'b1111, 1'b0);
      set_row(5,  1'b0, 32'h0000_720c, '0,            4'b0000, 1'b1);
      // Lines A, B and C all map to set 2
      set_row(6,  1'b0, 32'h0001_0040, '0,            4'b0000, 1'b1);
      set_row(7,  1'b0, 32'h0002_0044, '0,            4'b0000, 1'b1);
      set_row(8,  1'b0, 32'h0001_0050, '0,            4'b0000, 1'b0);
      // C replaces B, A stays
      set_row(9,  1'b0, 32'h0003_0048, '0,            4'b0000, 1'b1);
      set_row(10, 1'b0, 32'h0001_0054, '0,            4'b0000, 1'b0);
      set_row(11, 1'b0, 32'h0002_0044, '0,            4'b0000, 1'b1);
      set_row(12, 1'b0, 32'h0001_0040, '0,            4'b0000, 1'b0);
      set_row(13, 1'b1, 32'h0001_0058, 32'hdead_beef, 4'b1001, 1'b0);
      set_row(14, 1'b0, 32'h0001_0058, '0,            4'b0000, 1'b0);
   endtask

   task automatic drive_req(input logic we, input addr_t a, input word_t d, input bsel_t be);
      req_valid_i <= 1'b1;
      req_we_i    <= we;
      req_addr_i  <= a;
      req_wdata_i <= d;
      req_bsel_i  <= be;
   endtask

   // Ready only moves on clock edges, so the falling edge shows the next one
   task automatic wait_ready();
      @(negedge clk);
      while (!req_ready_o)
         @(negedge clk);
   endtask

   task automatic run_row(input int idx);
      addr_t      a;
      word_t      exp_data;
      logic       first_rsp;
      logic       saw_refill;
      line_addr_t seen_line;
      int         lat;
      int         err_before;
      err_before = err_cnt;
      a          = tbl_addr[idx];
      saw_refill = 1'b0;
      seen_line  = '0;
      @(posedge clk);
      drive_req(tbl_we[idx], a, tbl_wdata[idx], tbl_bsel[idx]);
      wait_ready();
      // Accepting edge
      @(posedge clk);
      req_valid_i <= 1'b0;
      if (tbl_we[idx])
         mem_write(a, tbl_wdata[idx], tbl_bsel[idx]);
      exp_data = mem_read(a);
      @(negedge clk);
      first_rsp = rsp_valid_o;
      lat       = 1;
      while (!rsp_valid_o) begin
         if (refill_req_o && !saw_refill) begin
            saw_refill = 1'b1;
            seen_line  = refill_addr_o;
         end
         @(negedge clk);
         lat++;
      end
      // Only a read miss may take longer than one cycle
      check_flag("rsp_valid_o", first_rsp, !tbl_refill[idx]);
      check_flag("refill_req_o", saw_refill, tbl_refill[idx]);
      if (saw_refill)
         check_line("refill_addr_o", seen_line, a[`DC_ADDR_W-1:`DC_BLOCK_W]);
      if (!tbl_we[idx])
         check_word("rsp_rdata_o", rsp_rdata_o, exp_data);
      test_cnt++;
      if (err_cnt != err_before)
         test_fail_cnt++;
      $display("test %0d %s 0x%08h latency %0d refill %0d %s", idx,
               tbl_we[idx] ? "write" : "read", a, lat, saw_refill,
               (err_cnt == err_before) ? "ok" : "FAILED");
   endtask

   // Reads of a resident line, one accepted per cycle
   task automatic run_burst();
      int i;
      int err_before;
      err_before = err_cnt;
      @(posedge clk);
      drive_req(1'b0, BURST_BASE, '0, '0);
      wait_ready();
      for (i = 0; i < BURST_LEN; i++) begin
         @(posedge clk);
         if (i < BURST_LEN - 1)
            drive_req(1'b0, addr_t'(BURST_BASE + 4 * (i + 1)), '0, '0);
         else
            req_valid_i <= 1'b0;
         @(negedge clk);
         check_flag("rsp_valid_o", rsp_valid_o, 1'b1);
         check_word("rsp_rdata_o", rsp_rdata_o, mem_read(addr_t'(BURST_BASE + 4 * i)));
         if (i < BURST_LEN - 1)
            check_flag("req_ready_o", req_ready_o, 1'b1);
      end
      test_cnt++;
      if (err_cnt != err_before)
         test_fail_cnt++;
      $display("test burst of %0d hits at 0x%08h %s", BURST_LEN, BURST_BASE,
               (err_cnt == err_before) ? "ok" : "FAILED");
   endtask

   // Refill responder, words from the shadow with random gaps
   always @(posedge clk) begin
      if (rst) begin
         refill_valid_i <= 1'b0;
         refill_data_i  <= '0;
         words_sent     <= 0;
         gap_rng        <= SEED;
      end else begin
         refill_valid_i <= 1'b0;
         if (!refill_req_o) begin
            words_sent <= 0;
         end else if (words_sent < `DC_WORDS) begin
            gap_rng <= xorshift32(gap_rng);
            if (gap_rng[2:0] >= 3'd3) begin
               refill_valid_i <= 1'b1;
               refill_data_i  <= mem_read({refill_addr_o, word_ofs_t'(words_sent), 2'b00});
               words_sent     <= words_sent + 1;
            end
         end
      end
   end

   // Run limit
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
         $display("=== FAIL ===");
         $finish;
      end
   end

   initial begin
      clk            = 1'b0;
      rst            = 1'b1;
      req_valid_i    = 1'b0;
      req_we_i       = 1'b0;
      req_addr_i     = '0;
      req_wdata_i    = '0;
      req_bsel_i     = '0;
      refill_valid_i = 1'b0;
      refill_data_i  = '0;
      cycle_cnt      = 0;
      err_cnt        = 0;
      test_cnt       = 0;
      test_fail_cnt  = 0;
      load_table();
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      for (r = 0; r < NUM_ROWS; r++)
         run_row(r);
      run_burst();
      $display("tests %0d, passed %0d, failed %0d, check errors %0d",
               test_cnt, test_cnt - test_fail_cnt, test_fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
source/dcache_pkg.sv
source/dcache_dpram.sv
source/dcache_lookup_stage.sv
source/dcache_hit_stage.sv
source/dcache_refill_engine.sv
source/dcache_top.sv
verification/dcache_tb.sv
